/* hw/display_cfg.svh */
`ifndef DISPLAY_CFG_SVH
`define DISPLAY_CFG_SVH

// ==================================================
// Display geometry and palette
// ==================================================
`define DP_RES_X         400
`define DP_RES_Y         300
`define DP_PALETTE_LEN   256
`define DP_COLOR_BITS    12

// ==================================================
// Core memory and control
// ==================================================
`define DP_RAM_WORDS     1024       // Scratch RAM depth in words.

// Control input bit that holds core and drawing state in reset.
`define DP_CTL_RESET_BIT 23

// Status after power-on or control reset. Bit 4 marks "not yet started".
`define DP_STATUS_RESET  32'h0000_0010

`endif

/* hw/display_pkg.sv */
`include "display_cfg.svh"

package display_pkg;

    typedef logic [$clog2(`DP_RES_X)-1:0]       coord_x_t;
    typedef logic [$clog2(`DP_RES_Y)-1:0]       coord_y_t;
    typedef logic [$clog2(`DP_PALETTE_LEN)-1:0] pal_index_t;
    typedef logic [`DP_COLOR_BITS-1:0]          color_t;

    // Target of a core bus access.
    typedef enum logic [2:0] {
        REGION_RAM,
        REGION_REGS,
        REGION_PALETTE,
        REGION_PIXEL,
        REGION_NONE
    } region_t;

    // Word offsets inside the register region.
    localparam logic [2:0] REG_STATUS  = 3'd0;
    localparam logic [2:0] REG_CONTROL = 3'd1;
    localparam logic [2:0] REG_CURSOR  = 3'd2;
    localparam logic [2:0] REG_FILL    = 3'd3;
    localparam logic [2:0] REG_RUN     = 3'd4;

    // RV32I major opcodes that draw_core understands.
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_t;

endpackage

/* hw/draw_core.sv */
`include "display_cfg.svh"
`timescale 1ns/1ps

module draw_core (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              sub_rst,
    output logic [$clog2(`DP_RAM_WORDS)-1:0]  imem_addr,
    input  logic [31:0]                       imem_data,
    output logic [31:0]                       bus_addr,
    output logic [31:0]                       bus_wr_data,
    output logic                              bus_wr_en,
    output logic                              bus_rd_en,
    input  logic [31:0]                       bus_rd_data
);
    import display_pkg::*;

    localparam int AW = $clog2(`DP_RAM_WORDS);

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_EXEC,
        ST_MEM
    } state_t;

    state_t      state;
    logic [31:0] pc;
    logic [31:0] regs [32];

    opcode_t     opcode;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] imm_u;

    logic [31:0] next_pc;
    logic        ex_wb_en;
    logic [31:0] ex_wb_data;
    logic        ex_mem;
    logic        ex_store;

    logic [31:0] mem_addr_q;
    logic [31:0] mem_data_q;
    logic [4:0]  mem_rd_q;
    logic        mem_store_q;

    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;

    // ==================================================
    // Decode
    // ==================================================
    assign opcode = opcode_t'(imem_data[6:0]);
    assign rd     = imem_data[11:7];
    assign funct3 = imem_data[14:12];
    assign rs1    = imem_data[19:15];
    assign rs2    = imem_data[24:20];
    assign funct7 = imem_data[31:25];

    assign imm_i = {{20{imem_data[31]}}, imem_data[31:20]};
    assign imm_s = {{20{imem_data[31]}}, imem_data[31:25], imem_data[11:7]};
    assign imm_b = {{20{imem_data[31]}}, imem_data[7], imem_data[30:25],
                    imem_data[11:8], 1'b0};
    assign imm_j = {{12{imem_data[31]}}, imem_data[19:12], imem_data[20],
                    imem_data[30:21], 1'b0};
    assign imm_u = {imem_data[31:12], 12'b0};

    assign rs1_val = (rs1 == 5'd0) ? 32'd0 : regs[rs1];  // x0 reads as zero.
    assign rs2_val = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

    always_comb begin
        next_pc    = pc + 32'd4;
        ex_wb_en   = 1'b0;
        ex_wb_data = 32'd0;
        ex_mem     = 1'b0;
        ex_store   = 1'b0;
        case (opcode)
            OP_LUI: begin
                ex_wb_en   = 1'b1;
                ex_wb_data = imm_u;
            end
            OP_IMM: begin
                ex_wb_en   = (funct3 == 3'b000);               // ADDI only.
                ex_wb_data = rs1_val + imm_i;
            end
            OP_REG: begin
                ex_wb_en   = (funct3 == 3'b000) && (funct7 == 7'd0);  // ADD only.
                ex_wb_data = rs1_val + rs2_val;
            end
            OP_LOAD:  ex_mem = (funct3 == 3'b010);
            OP_STORE: begin
                ex_mem   = (funct3 == 3'b010);
                ex_store = 1'b1;
            end
            OP_BRANCH: begin
                if (funct3 == 3'b001 && rs1_val != rs2_val) begin  // BNE.
                    next_pc = pc + imm_b;
                end
            end
            OP_JAL: begin
                ex_wb_en   = 1'b1;
                ex_wb_data = pc + 32'd4;
                next_pc    = pc + imm_j;
            end
            default: ;
        endcase
    end

    // ==================================================
    // Sequencing
    // ==================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_FETCH;
            pc    <= 32'd0;
        end else if (sub_rst) begin
            state <= ST_FETCH;
            pc    <= 32'd0;
        end else begin
            case (state)
                ST_FETCH: state <= ST_EXEC;
                ST_EXEC: begin
                    pc    <= next_pc;
                    state <= ex_mem ? ST_MEM : ST_FETCH;
                end
                default: state <= ST_FETCH;
            endcase
        end
    end

    // Access captured in execute, strobed in the memory cycle.
    always_ff @(posedge clk) begin
        if (state == ST_EXEC && ex_mem) begin
            mem_addr_q  <= rs1_val + (ex_store ? imm_s : imm_i);
            mem_data_q  <= rs2_val;
            mem_rd_q    <= rd;
            mem_store_q <= ex_store;
        end
    end

    assign rf_we    = !sub_rst && ((state == ST_EXEC && ex_wb_en) ||
                                   (state == ST_MEM && !mem_store_q));
    assign rf_waddr = (state == ST_MEM) ? mem_rd_q : rd;
    assign rf_wdata = (state == ST_MEM) ? bus_rd_data : ex_wb_data;

    always_ff @(posedge clk) begin
        if (rf_we && rf_waddr != 5'd0) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    assign imem_addr   = pc[AW+1:2];
    assign bus_addr    = mem_addr_q;
    assign bus_wr_data = mem_data_q;
    assign bus_wr_en   = (state == ST_MEM) && mem_store_q;
    assign bus_rd_en   = (state == ST_MEM) && !mem_store_q;

endmodule

/* hw/memory_map.sv */
`include "display_cfg.svh"
`timescale 1ns/1ps

module memory_map (
    input  logic [31:0]                      bus_addr,
    input  logic [31:0]                      bus_wr_data,
    input  logic                             bus_wr_en,
    input  logic                             bus_rd_en,
    output logic [31:0]                      bus_rd_data,
    output logic [$clog2(`DP_RAM_WORDS)-1:0] ram_addr,
    output logic [31:0]                      ram_wr_data,
    output logic                             ram_wr_en,
    input  logic [31:0]                      ram_rd_data,
    output display_pkg::region_t             reg_sel,
    output logic [2:0]                       reg_offset,
    output logic [31:0]                      reg_wr_data,
    output logic                             reg_wr_en,
    input  logic [31:0]                      reg_rd_data,
    output display_pkg::pal_index_t          palette_wr_index,
    output display_pkg::color_t              palette_wr_color,
    output logic                             palette_wr_en
);
    import display_pkg::*;

    localparam int AW = $clog2(`DP_RAM_WORDS);
    localparam int PW = $bits(pal_index_t);

    region_t region;

    always_comb begin
        case (bus_addr[31:28])
            4'h0:    region = REGION_RAM;
            4'h1:    region = REGION_REGS;
            4'h2:    region = REGION_PALETTE;
            4'h3:    region = REGION_PIXEL;
            default: region = REGION_NONE;
        endcase
    end

    assign ram_addr    = bus_addr[AW+1:2];
    assign ram_wr_data = bus_wr_data;
    assign ram_wr_en   = bus_wr_en && (region == REGION_RAM);

    // Pixel stores share the register path. pixel_writer tells them apart by reg_sel.
    assign reg_sel     = region;
    assign reg_offset  = bus_addr[4:2];
    assign reg_wr_data = bus_wr_data;
    assign reg_wr_en   = bus_wr_en && (region == REGION_REGS || region == REGION_PIXEL);

    assign palette_wr_index = bus_addr[PW+1:2];
    assign palette_wr_color = bus_wr_data[$bits(color_t)-1:0];
    assign palette_wr_en    = bus_wr_en && (region == REGION_PALETTE);

    always_comb begin
        bus_rd_data = 32'd0;  // Palette, pixel and unmapped reads.
        if (bus_rd_en) begin
            case (region)
                REGION_RAM:  bus_rd_data = ram_rd_data;
                REGION_REGS: bus_rd_data = reg_rd_data;
                default:     bus_rd_data = 32'd0;
            endcase
        end
    end

endmodule

/* hw/data_ram.sv */
`include "display_cfg.svh"
`timescale 1ns/1ps

module data_ram (
    input  logic                             clk,
    input  logic [$clog2(`DP_RAM_WORDS)-1:0] imem_addr,
    output logic [31:0]                      imem_data,
    input  logic [$clog2(`DP_RAM_WORDS)-1:0] ram_addr,
    input  logic [31:0]                      ram_wr_data,
    input  logic                             ram_wr_en,
    output logic [31:0]                      ram_rd_data,
    input  logic                             load_en,
    input  logic [$clog2(`DP_RAM_WORDS)-1:0] load_addr,
    input  logic [31:0]                      load_data
);
    logic [31:0] mem [`DP_RAM_WORDS];

    always_ff @(posedge clk) begin
        imem_data <= mem[imem_addr];  // Registered fetch.
        if (load_en) begin
            mem[load_addr] <= load_data;  // Host wins.
        end else if (ram_wr_en) begin
            mem[ram_addr] <= ram_wr_data;
        end
    end

    assign ram_rd_data = mem[ram_addr];

endmodule

/* hw/pixel_writer.sv */
`include "display_cfg.svh"
`timescale 1ns/1ps

module pixel_writer (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    sub_rst,
    input  logic [31:0]             control,
    input  display_pkg::region_t    reg_sel,
    input  logic [2:0]              reg_offset,
    input  logic [31:0]             reg_wr_data,
    input  logic                    reg_wr_en,
    output logic [31:0]             reg_rd_data,
    output logic [31:0]             status,
    output display_pkg::coord_x_t   fb_wr_x,
    output display_pkg::coord_y_t   fb_wr_y,
    output display_pkg::pal_index_t fb_wr_index,
    output logic                    fb_wr_en
);
    import display_pkg::*;

    localparam logic [31:0] STATUS_RST = `DP_STATUS_RESET;

    coord_x_t    cur_x;
    coord_y_t    cur_y;
    pal_index_t  fill_idx;
    logic [31:0] run_left;
    logic [23:0] status_hi;
    logic        init_flag;
    logic        busy;
    logic        reg_wr;
    logic        pix_wr;

    assign busy   = (run_left != 32'd0);
    assign reg_wr = reg_wr_en && (reg_sel == REGION_REGS);
    assign pix_wr = reg_wr_en && (reg_sel == REGION_PIXEL) && !busy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cur_x     <= '0;
            cur_y     <= '0;
            fill_idx  <= '0;
            run_left  <= 32'd0;
            status_hi <= STATUS_RST[31:8];
            init_flag <= STATUS_RST[4];
        end else if (sub_rst) begin
            cur_x     <= '0;
            cur_y     <= '0;
            fill_idx  <= '0;
            run_left  <= 32'd0;
            status_hi <= STATUS_RST[31:8];
            init_flag <= STATUS_RST[4];
        end else begin
            if (busy) begin
                run_left <= run_left - 32'd1;
                if (cur_x == coord_x_t'(`DP_RES_X - 1)) begin  // Row wrap.
                    cur_x <= '0;
                    cur_y <= (cur_y == coord_y_t'(`DP_RES_Y - 1)) ? '0 : cur_y + 1'b1;
                end else begin
                    cur_x <= cur_x + 1'b1;
                end
            end else if (reg_wr) begin
                case (reg_offset)
                    REG_CURSOR: begin
                        cur_x <= reg_wr_data[8:0];
                        cur_y <= reg_wr_data[17:9];
                    end
                    REG_FILL: fill_idx <= reg_wr_data[7:0];
                    REG_RUN:  run_left <= reg_wr_data;
                    default: ;
                endcase
            end
            if (reg_wr && reg_offset == REG_STATUS) begin
                status_hi <= reg_wr_data[31:8];
                init_flag <= 1'b0;
            end
        end
    end

    assign status = {status_hi, 3'b000, init_flag, 3'b000, busy};

    always_comb begin
        case (reg_offset)
            REG_STATUS:  reg_rd_data = status;
            REG_CONTROL: reg_rd_data = control;
            REG_CURSOR:  reg_rd_data = {14'd0, cur_y, cur_x};
            REG_FILL:    reg_rd_data = {24'd0, fill_idx};
            REG_RUN:     reg_rd_data = run_left;
            default:     reg_rd_data = 32'd0;
        endcase
    end

    // Run pixels while busy, otherwise a direct store unpacked from the data.
    assign fb_wr_x     = busy ? cur_x : reg_wr_data[8:0];
    assign fb_wr_y     = busy ? cur_y : reg_wr_data[17:9];
    assign fb_wr_index = busy ? fill_idx : reg_wr_data[25:18];
    assign fb_wr_en    = busy || pix_wr;

endmodule

/* hw/display_processor.sv */
`include "display_cfg.svh"
`timescale 1ns/1ps

module display_processor (
    input  logic                             clk,
    input  logic                             arst_n,
    output logic [31:0]                      status,
    input  logic [31:0]                      control,
    input  logic                             load_en,
    input  logic [$clog2(`DP_RAM_WORDS)-1:0] load_addr,
    input  logic [31:0]                      load_data,
    output display_pkg::pal_index_t          palette_wr_index,
    output display_pkg::color_t              palette_wr_color,
    output logic                             palette_wr_en,
    output display_pkg::coord_x_t            fb_wr_x,
    output display_pkg::coord_y_t            fb_wr_y,
    output display_pkg::pal_index_t          fb_wr_index,
    output logic                             fb_wr_en
);
    import display_pkg::*;

    localparam int AW = $clog2(`DP_RAM_WORDS);

    logic          sub_rst;
    logic [AW-1:0] imem_addr;
    logic [31:0]   imem_data;
    logic [31:0]   bus_addr;
    logic [31:0]   bus_wr_data;
    logic          bus_wr_en;
    logic          bus_rd_en;
    logic [31:0]   bus_rd_data;
    logic [AW-1:0] ram_addr;
    logic [31:0]   ram_wr_data;
    logic          ram_wr_en;
    logic [31:0]   ram_rd_data;
    region_t       reg_sel;
    logic [2:0]    reg_offset;
    logic [31:0]   reg_wr_data;
    logic          reg_wr_en;
    logic [31:0]   reg_rd_data;

    // Control reset, sampled so it acts like a synchronous reset.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sub_rst <= 1'b0;
        end else begin
            sub_rst <= control[`DP_CTL_RESET_BIT];
        end
    end

    draw_core u_core (
        .clk         (clk),
        .arst_n      (arst_n),
        .sub_rst     (sub_rst),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .bus_addr    (bus_addr),
        .bus_wr_data (bus_wr_data),
        .bus_wr_en   (bus_wr_en),
        .bus_rd_en   (bus_rd_en),
        .bus_rd_data (bus_rd_data)
    );

    memory_map u_map (
        .bus_addr         (bus_addr),
        .bus_wr_data      (bus_wr_data),
        .bus_wr_en        (bus_wr_en),
        .bus_rd_en        (bus_rd_en),
        .bus_rd_data      (bus_rd_data),
        .ram_addr         (ram_addr),
        .ram_wr_data      (ram_wr_data),
        .ram_wr_en        (ram_wr_en),
        .ram_rd_data      (ram_rd_data),
        .reg_sel          (reg_sel),
        .reg_offset       (reg_offset),
        .reg_wr_data      (reg_wr_data),
        .reg_wr_en        (reg_wr_en),
        .reg_rd_data      (reg_rd_data),
        .palette_wr_index (palette_wr_index),
        .palette_wr_color (palette_wr_color),
        .palette_wr_en    (palette_wr_en)
    );

    data_ram u_ram (
        .clk         (clk),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .ram_addr    (ram_addr),
        .ram_wr_data (ram_wr_data),
        .ram_wr_en   (ram_wr_en),
        .ram_rd_data (ram_rd_data),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data)
    );

    pixel_writer u_pixel (
        .clk         (clk),
        .arst_n      (arst_n),
        .sub_rst     (sub_rst),
        .control     (control),
        .reg_sel     (reg_sel),
        .reg_offset  (reg_offset),
        .reg_wr_data (reg_wr_data),
        .reg_wr_en   (reg_wr_en),
        .reg_rd_data (reg_rd_data),
        .status      (status),
        .fb_wr_x     (fb_wr_x),
        .fb_wr_y     (fb_wr_y),
        .fb_wr_index (fb_wr_index),
        .fb_wr_en    (fb_wr_en)
    );

endmodule

/* verif/display_checker.sv */
`include "display_cfg.svh"
`timescale 1ns/1ps

module display_checker #(
    parameter int GOLDEN_AW = 7
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [31:0]             control,
    input  logic [31:0]             status,
    input  display_pkg::pal_index_t palette_wr_index,
    input  display_pkg::color_t     palette_wr_color,
    input  logic                    palette_wr_en,
    input  display_pkg::coord_x_t   fb_wr_x,
    input  display_pkg::coord_y_t   fb_wr_y,
    input  display_pkg::pal_index_t fb_wr_index,
    input  logic                    fb_wr_en,
    input  logic [31:0]             golden [2**GOLDEN_AW],
    input  logic                    final_check,
    output int                      seen_events,
    output int                      error_count
);
    import display_pkg::*;

    localparam logic [31:0] STATUS_RST   = `DP_STATUS_RESET;
    localparam logic [31:0] KIND_PALETTE = 32'd0;
    localparam logic [31:0] KIND_PIXEL   = 32'd1;

    int   prog_len;
    int   event_total;
    int   event_base;
    logic final_done = 1'b0;

    function automatic logic [31:0] word_at(input int idx);
        return golden[idx[GOLDEN_AW-1:0]];
    endfunction

    // Compare one observed write with the next record of the list.
    task automatic check_event(input logic [31:0] kind, input logic [31:0] a,
                               input logic [31:0] b, input logic [31:0] c);
        int rec;
        rec = event_base + 4 * seen_events;
        if (seen_events >= event_total) begin
            $display("unexpected extra %s write at %0d ns after all %0d expected events",
                     (kind == KIND_PALETTE) ? "palette" : "pixel", $time, event_total);
            error_count++;
        end else if (word_at(rec) != kind || word_at(rec + 1) != a ||
                     word_at(rec + 2) != b || word_at(rec + 3) != c) begin
            $display("error @ %0d ns: event %0d expected %0h/%0h/%0h/%0h, got %0h/%0h/%0h/%0h",
                     $time, seen_events, word_at(rec), word_at(rec + 1), word_at(rec + 2),
                     word_at(rec + 3), kind, a, b, c);
            error_count++;
        end
        seen_events++;
    endtask

    // ==================================================
    // Sampling on the rising edge
    // ==================================================
    always @(posedge clk) begin
        prog_len    = golden[0];
        event_total = word_at(prog_len + 1);
        event_base  = prog_len + 2;
        if (!arst_n) begin
            seen_events = 0;
            error_count = 0;
        end else begin
            if (control[`DP_CTL_RESET_BIT] && status != STATUS_RST) begin
                $display("error @ %0d ns: status 0x%h under control reset, expected 0x%h",
                         $time, status, STATUS_RST);
                error_count++;
            end
            if (palette_wr_en) begin
                check_event(KIND_PALETTE, 32'(palette_wr_index), 32'd0, 32'(palette_wr_color));
            end
            if (fb_wr_en) begin
                check_event(KIND_PIXEL, 32'(fb_wr_x), 32'(fb_wr_y), 32'(fb_wr_index));
            end
            if (final_check && !final_done) begin
                final_done = 1'b1;
                if (seen_events < event_total) begin
                    $display("missing events: only %0d of %0d expected writes appeared",
                             seen_events, event_total);
                    error_count++;
                end
                if (status != word_at(event_base + 4 * event_total)) begin
                    $display("error @ %0d ns: final status 0x%h, expected 0x%h", $time,
                             status, word_at(event_base + 4 * event_total));
                    error_count++;
                end
            end
        end
    end

endmodule

/* verif/tb_display_processor.sv */
`include "display_cfg.svh"
`timescale 1ns/1ps

module tb_display_processor;
    import display_pkg::*;

    localparam int GOLDEN_AW     = 7;
    localparam int RAM_AW        = $clog2(`DP_RAM_WORDS);
    localparam int RESTART_AFTER = 4;   // Writes seen before the mid-program control reset.
    localparam int SETTLE_CYCLES = 16;

    logic              clk;
    logic              arst_n;
    logic [31:0]       status;
    logic [31:0]       control;
    logic              load_en;
    logic [RAM_AW-1:0] load_addr;
    logic [31:0]       load_data;
    pal_index_t        palette_wr_index;
    color_t            palette_wr_color;
    logic              palette_wr_en;
    coord_x_t          fb_wr_x;
    coord_y_t          fb_wr_y;
    pal_index_t        fb_wr_index;
    logic              fb_wr_en;

    logic [31:0]       golden [2**GOLDEN_AW];
    logic              final_check;
    int                seen_events;
    int                error_count;
    int                prog_len;
    int                event_total;
    int                cycle_limit;
    int                cycle_count;

    display_processor u_dut (
        .clk              (clk),
        .arst_n           (arst_n),
        .status           (status),
        .control          (control),
        .load_en          (load_en),
        .load_addr        (load_addr),
        .load_data        (load_data),
        .palette_wr_index (palette_wr_index),
        .palette_wr_color (palette_wr_color),
        .palette_wr_en    (palette_wr_en),
        .fb_wr_x          (fb_wr_x),
        .fb_wr_y          (fb_wr_y),
        .fb_wr_index      (fb_wr_index),
        .fb_wr_en         (fb_wr_en)
    );

    display_checker #(.GOLDEN_AW(GOLDEN_AW)) u_checker (
        .clk              (clk),
        .arst_n           (arst_n),
        .control          (control),
        .status           (status),
        .palette_wr_index (palette_wr_index),
        .palette_wr_color (palette_wr_color),
        .palette_wr_en    (palette_wr_en),
        .fb_wr_x          (fb_wr_x),
        .fb_wr_y          (fb_wr_y),
        .fb_wr_index      (fb_wr_index),
        .fb_wr_en         (fb_wr_en),
        .golden           (golden),
        .final_check      (final_check),
        .seen_events      (seen_events),
        .error_count      (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic print_summary();
        $display("checks done: %0d of %0d events seen, %0d errors",
                 seen_events, event_total, error_count);
    endtask

    // Program image goes in through the host port, one word per cycle.
    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = RAM_AW'(i);
            load_data = golden[GOLDEN_AW'(i + 1)];
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    // ==================================================
    // Watchdog
    // ==================================================
    initial begin
        cycle_count = 0;
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the program did not finish within %0d cycles", cycle_limit);
        print_summary();
        $display("Simulation failed");
        $finish;
    end

    // ==================================================
    // Stimulus
    // ==================================================
    initial begin
        arst_n      = 1'b0;
        control     = 32'd0;
        control[`DP_CTL_RESET_BIT] = 1'b1;  // Drawing held while the program loads.
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = 32'd0;
        final_check = 1'b0;
        $readmemh("verif/display_golden.mem", golden);
        prog_len    = golden[0];
        event_total = golden[GOLDEN_AW'(prog_len + 1)];
        if (prog_len < 1 || prog_len > `DP_RAM_WORDS || event_total < 1 ||
            prog_len + 3 + 4 * event_total > 2**GOLDEN_AW) begin
            $display("golden file is missing or its layout is invalid");
            $display("Simulation failed");
            $finish;
        end else begin
            cycle_limit = prog_len * event_total * 8;
            repeat (2) @(negedge clk);
            arst_n = 1'b1;
            load_program();
            control[`DP_CTL_RESET_BIT] = 1'b0;

            // Restart the program part way through.
            while (seen_events < RESTART_AFTER) @(negedge clk);
            control[`DP_CTL_RESET_BIT] = 1'b1;
            repeat (2) @(negedge clk);
            control[`DP_CTL_RESET_BIT] = 1'b0;

            while (status[4]) @(negedge clk);  // Cleared by the last status store.
            repeat (SETTLE_CYCLES) @(negedge clk);
            final_check = 1'b1;
            repeat (2) @(negedge clk);
            print_summary();
            if (error_count == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

/* verif/display_golden.mem */
// Program length, program words, event count, event records, final status.
// Event columns: kind (0 palette, 1 pixel), x or palette index, y, colour or pixel index.
0000001c
200000b7
0f000113
0020aa23
123451b7
7ab18193
3e30ae23
30000237
016862b7
46428293
00522023
03fe5337
78f30313
00622023
100003b7
00001437
58c40413
0083a423
03300493
0093a623
00600513
00200593
00a3a823
00622023
0023a623
00b3a823
cafe5637
00c3a023
0000006f
00000010
0 005 000 0f0
0 0ff 000 7ab
1 064 032 05a
1 18f 12b 0ff
0 005 000 0f0
0 0ff 000 7ab
1 064 032 05a
1 18f 12b 0ff
1 18c 00a 033
1 18d 00a 033
1 18e 00a 033
1 18f 00a 033
1 000 00b 033
1 001 00b 033
1 002 00b 033
1 003 00b 033
cafe5000

/* sim.f */
+incdir+hw
hw/display_pkg.sv
hw/draw_core.sv
hw/memory_map.sv
hw/data_ram.sv
hw/pixel_writer.sv
hw/display_processor.sv
verif/display_checker.sv
verif/tb_display_processor.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f sim.f --top-module tb_display_processor \
    -o tb_display_processor &&
./obj_dir/tb_display_processor | tee sim.log &&
grep -q "Simulation passed" sim.log &&
echo "run_sim: run passed" ||
{ echo "run_sim: run failed"; exit 1; }
